// ==== compile.f ====
hw/cpu_pkg.sv
hw/alu8.sv
hw/register_file.sv
hw/opcode_decoder.sv
hw/bus_sequencer.sv
hw/cpu_top.sv
tb/mem_model.sv
tb/tb_cpu.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_cpu -f compile.f -o tb_cpu_sim &&
	./obj_dir/tb_cpu_sim > sim.log 2>&1 ||
	{ cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Something failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// ==== tb/tb_cpu.sv ====
/*
 * testbench for cpu_top with small programs, reference ALU model,
 * write checker and cycle timeout
 */

`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*; ();

	localparam addr_t VEC_ADDR        = 16'hFFFE;
	localparam int    N_TESTS         = 5;
	localparam int    CYCLES_PER_TEST = 400;
	localparam int    TIMEOUT_CYCLES  = N_TESTS * CYCLES_PER_TEST;
	localparam int    SETTLE_CYCLES   = 30; // quiet time to catch stray writes

	typedef struct packed {
		addr_t addr;
		byte_t data;
	} wr_t;

	typedef struct packed {
		byte_t res;
		ccr_t  f;
	} alu_res_t;

	logic        cpu_clk = 1'b0;
	logic        k_reset;
	byte_t       cpu_data_i;
	addr_t       cpu_addr_o;
	byte_t       cpu_data_o;
	logic        cpu_oe_o;
	logic        cpu_we_o;
	wr_t         exp_q[$];  // writes still to come in order
	addr_t       rd_log[$]; // address of every read pulse
	wr_t         exp_w;
	addr_t       prog_ptr;
	int          errors;
	int          err_before;
	int          pass_cnt;
	int          fail_cnt;
	int          cycles = 0;

	cpu_top #(
		.RESET_VECTOR(VEC_ADDR)
	) DUT (
		.cpu_clk   (cpu_clk),
		.k_reset   (k_reset),
		.cpu_data_i(cpu_data_i),
		.cpu_addr_o(cpu_addr_o),
		.cpu_data_o(cpu_data_o),
		.cpu_oe_o  (cpu_oe_o),
		.cpu_we_o  (cpu_we_o)
	);

	mem_model u_mem (
		.cpu_clk(cpu_clk),
		.addr_i (cpu_addr_o),
		.wdata_i(cpu_data_o),
		.oe_i   (cpu_oe_o),
		.we_i   (cpu_we_o),
		.rdata_o(cpu_data_i)
	);

	always #5 cpu_clk = ~cpu_clk;

	// expected byte and flags from the 6809 rules
	function automatic alu_res_t ref_alu(input alu_op_e op, input byte_t a, input byte_t b,
		input logic c_in);
		alu_res_t r;
		int ua;
		int ub;
		int sa;
		int sb;
		ua = int'(a);
		ub = int'(b);
		sa = int'($signed(a));
		sb = int'($signed(b));
		r.f.v = 1'b0;
		r.f.c = c_in;
		case (op)
			ALU_ADD:
			begin
				r.res = byte_t'(ua + ub);
				r.f.c = (ua + ub > 255);
				r.f.v = (sa + sb > 127) || (sa + sb < -128);
			end
			ALU_SUB:
			begin
				r.res = byte_t'(ua - ub);
				r.f.c = (ua < ub); // borrow
				r.f.v = (sa - sb > 127) || (sa - sb < -128);
			end
			ALU_AND:
				r.res = a & b;
			default:
				r.res = b;
		endcase
		r.f.n = r.res[7];
		r.f.z = (r.res == 8'h00);
		return r;
	endfunction

	function automatic byte_t rand_byte();
		logic [31:0] r;
		r = $urandom;
		return r[7:0];
	endfunction

	function automatic addr_t rand_addr(input logic [3:0] page);
		logic [31:0] r;
		r = $urandom;
		return {page, r[11:0]};
	endfunction

	task automatic check_eq(input logic [15:0] got, input logic [15:0] exp, input string what);
		if (got !== exp)
		begin
			$display("** Error at %0t: %s is %04h, expected %04h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic poke(input addr_t a, input byte_t v);
		u_mem.mem[a] = v;
	endtask

	task automatic emit(input byte_t v);
		poke(prog_ptr, v);
		prog_ptr = prog_ptr + 16'h0001;
	endtask

	task automatic short_instr(input byte_t op, input byte_t arg);
		emit(op);
		emit(arg);
	endtask

	task automatic long_instr(input byte_t op, input addr_t a);
		emit(op);
		emit(a[15:8]);
		emit(a[7:0]);
	endtask

	task automatic loop_here();
		short_instr(8'h20, 8'hFE); // BRA to itself
	endtask

	task automatic expect_write(input addr_t a, input byte_t d);
		wr_t w;
		w.addr = a;
		w.data = d;
		exp_q.push_back(w);
	endtask

	// reset on, memory filled, vector written
	task automatic begin_test(input addr_t vec);
		int a;
		@(negedge cpu_clk);
		k_reset = 1'b1;
		err_before = errors;
		exp_q.delete();
		rd_log.delete();
		for (a = 0; a < 65536; a++)
			poke(addr_t'(a), byte_t'(a >> 8) ^ byte_t'(a) ^ 8'h3C);
		poke(VEC_ADDR, vec[15:8]);
		poke(VEC_ADDR + 16'h0001, vec[7:0]);
		prog_ptr = vec;
	endtask

	task automatic release_reset();
		repeat (16) @(negedge cpu_clk);
		k_reset = 1'b0;
	endtask

	task automatic finish_test(input int num, input string name);
		while (exp_q.size() != 0)
			@(negedge cpu_clk);
		repeat (SETTLE_CYCLES) @(negedge cpu_clk);
		if (errors == err_before)
		begin
			pass_cnt++;
			$display("test %0d (%s) passed", num, name);
		end
		else
		begin
			fail_cnt++;
			$display("test %0d (%s) failed", num, name);
		end
	endtask

	// checks every write pulse against the expected list
	always @(posedge cpu_clk)
	begin
		if (!k_reset && cpu_we_o)
		begin
			if (exp_q.size() == 0)
			begin
				$display("unexpected write of %02h to %04h at %0t",
					cpu_data_o, cpu_addr_o, $time);
				errors++;
			end
			else
			begin
				exp_w = exp_q.pop_front();
				check_eq(cpu_addr_o, exp_w.addr, "write address");
				check_eq(16'(cpu_data_o), 16'(exp_w.data), "write data");
			end
		end
		if (!k_reset && cpu_oe_o)
			rd_log.push_back(cpu_addr_o);
	end

	always @(posedge cpu_clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout: run stopped after %0d cycles, a test never finished", cycles);
			$display("Something failed");
			$finish;
		end
	end

	task automatic reset_vector_test();
		addr_t vec;
		vec = rand_addr(4'h1);
		begin_test(vec);
		loop_here();
		release_reset();
		while (rd_log.size() < 3)
			@(negedge cpu_clk);
		check_eq(rd_log[0], VEC_ADDR, "first read address");
		check_eq(rd_log[1], VEC_ADDR + 16'h0001, "second read address");
		check_eq(rd_log[2], vec, "first fetch address");
		finish_test(1, "reset vector");
	endtask

	task automatic alu_imm_test();
		byte_t    op_code [4] = '{8'h8B, 8'h80, 8'h84, 8'hCB}; // ADDA SUBA ANDA ADDB
		alu_op_e  ops [4]     = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_ADD};
		byte_t    x;
		byte_t    y;
		alu_res_t r;
		int       i;
		begin_test(16'h1000);
		for (i = 0; i < 4; i++)
		begin
			x = rand_byte();
			y = rand_byte();
			r = ref_alu(ops[i], x, y, 1'b0);
			short_instr((i < 3) ? 8'h86 : 8'hC6, x);             // LDA or LDB
			short_instr(op_code[i], y);
			long_instr((i < 3) ? 8'hB7 : 8'hF7, 16'h2000 + 16'(i)); // STA or STB
			expect_write(16'h2000 + 16'(i), r.res);
		end
		loop_here();
		release_reset();
		finish_test(2, "immediate alu ops");
	endtask

	task automatic branch_test();
		byte_t    x;
		byte_t    y;
		alu_res_t r;
		logic     is_eq;
		logic     taken;
		addr_t    mark;
		int       s;
		begin_test(16'h1000);
		for (s = 0; s < 4; s++)
		begin
			is_eq = (s < 2);
			x = rand_byte();
			y = (s % 2 == 0) ? (~x + 8'h01) : rand_byte(); // even rounds sum to zero
			r = ref_alu(ALU_ADD, x, y, 1'b0);
			taken = is_eq ? r.f.z : !r.f.z;
			mark = 16'h3000 + 16'(s);
			short_instr(8'h86, x);
			short_instr(8'h8B, y);
			short_instr(is_eq ? 8'h27 : 8'h26, 8'h05); // over LDB and STB
			short_instr(8'hC6, 8'h11);
			long_instr(8'hF7, mark);
			short_instr(8'hC6, 8'h22);
			long_instr(8'hF7, mark);
			if (!taken)
				expect_write(mark, 8'h11);
			expect_write(mark, 8'h22);
		end
		loop_here();
		release_reset();
		finish_test(3, "conditional branches");
	endtask

	task automatic mem_operand_test();
		addr_t src;
		byte_t val;
		byte_t dp;
		src = rand_addr(4'h4);
		val = rand_byte();
		dp = rand_byte();
		begin_test(16'h1000);
		poke(src, val);
		long_instr(8'hB6, src);  // LDA extended
		short_instr(8'h97, dp);  // STA direct on page zero
		loop_here();
		expect_write({8'h00, dp}, val);
		release_reset();
		finish_test(4, "direct and extended operands");
	endtask

	task automatic jmp_skip_test();
		byte_t k;
		k = rand_byte();
		begin_test(16'h1000);
		short_instr(8'h86, k);
		long_instr(8'h7E, 16'h1100);
		short_instr(8'h86, 8'hEE);  // jumped over
		long_instr(8'hB7, 16'h3000);
		loop_here();
		prog_ptr = 16'h1100;
		emit(8'h01);                // no such opcode in the core
		long_instr(8'hB7, 16'h3001);
		loop_here();
		expect_write(16'h3001, k);
		release_reset();
		finish_test(5, "jmp and skipped opcode");
	endtask

	initial
	begin
		k_reset = 1'b1;
		errors = 0;
		err_before = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		prog_ptr = '0;
		void'($urandom(32'h55a1));
		reset_vector_test();
		alu_imm_test();
		branch_test();
		mem_operand_test();
		jmp_skip_test();
		$display("%0d tests passed, %0d failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// ==== tb/mem_model.sv ====
/*
 * 64 KiB byte memory answering the core's read and write strobes
 */

`timescale 1ns/1ps

module mem_model import cpu_pkg::*; (
	input  logic  cpu_clk,
	input  addr_t addr_i,
	input  byte_t wdata_i,
	input  logic  oe_i,
	input  logic  we_i,
	output byte_t rdata_o
);

	byte_t mem [0:65535];
	byte_t rd_q = '0;

	// mid-cycle update, stable by the core's capture edge
	always @(negedge cpu_clk)
	begin
		if (oe_i)
			rd_q = mem[addr_i];
		if (we_i)
			mem[addr_i] = wdata_i;
	end

	assign rdata_o = rd_q;

endmodule

// ==== hw/cpu_top.sv ====
/*
 * core top level, sequencer, decoder, register file and ALU on the bus
 */

`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
	parameter addr_t RESET_VECTOR = 16'hFFFE
) (
	input  logic  cpu_clk,
	input  logic  k_reset,
	input  byte_t cpu_data_i,
	output addr_t cpu_addr_o,
	output byte_t cpu_data_o,
	output logic  cpu_oe_o,
	output logic  cpu_we_o
);

	decode_t  dec;
	rf_ctrl_t rf_ctrl;
	byte_t    opcode;
	byte_t    operand;       // immediate or memory operand, ALU right side
	addr_t    new_pc;
	addr_t    pc;
	byte_t    acc;           // accumulator picked by dec.reg_sel
	ccr_t     ccr;
	ccr_t     alu_ccr;
	byte_t    alu_result;
	logic     cond_true;

	bus_sequencer #(
		.RESET_VECTOR(RESET_VECTOR)
	) u_seq (
		.cpu_clk    (cpu_clk),
		.k_reset    (k_reset),
		.cpu_data_i (cpu_data_i),
		.dec_i      (dec),
		.pc_i       (pc),
		.acc_i      (acc),
		.cond_true_i(cond_true),
		.opcode_o   (opcode),
		.operand_o  (operand),
		.new_pc_o   (new_pc),
		.rf_ctrl_o  (rf_ctrl),
		.cpu_addr_o (cpu_addr_o),
		.cpu_data_o (cpu_data_o),
		.cpu_oe_o   (cpu_oe_o),
		.cpu_we_o   (cpu_we_o)
	);

	opcode_decoder u_dec (
		.opcode_i(opcode),
		.dec_o   (dec)
	);

	register_file u_regs (
		.cpu_clk    (cpu_clk),
		.k_reset    (k_reset),
		.ctrl_i     (rf_ctrl),
		.reg_sel_i  (dec.reg_sel),
		.acc_wdata_i(alu_result),
		.ccr_i      (alu_ccr),
		.new_pc_i   (new_pc),
		.pc_o       (pc),
		.acc_o      (acc),
		.ccr_o      (ccr)
	);

	alu8 u_alu (
		.op_i       (dec.alu_op),
		.a_i        (acc),
		.b_i        (operand),
		.ccr_i      (ccr),
		.cond_i     (dec.cond),
		.result_o   (alu_result),
		.ccr_o      (alu_ccr),
		.cond_true_o(cond_true)
	);

endmodule

// ==== hw/bus_sequencer.sv ====
/*
 * main state machine: reset vector, fetch, operand and memory reads,
 * execute, memory write and branch
 */

`timescale 1ns/1ps

module bus_sequencer import cpu_pkg::*; #(
	parameter addr_t RESET_VECTOR = 16'hFFFE
) (
	input  logic     cpu_clk,
	input  logic     k_reset,
	input  byte_t    cpu_data_i,
	input  decode_t  dec_i,
	input  addr_t    pc_i,
	input  byte_t    acc_i,
	input  logic     cond_true_i,
	output byte_t    opcode_o,
	output byte_t    operand_o,
	output addr_t    new_pc_o,
	output rf_ctrl_t rf_ctrl_o,
	output addr_t    cpu_addr_o,
	output byte_t    cpu_data_o,
	output logic     cpu_oe_o,
	output logic     cpu_we_o
);

	typedef enum logic [3:0] {
		ST_COLD,
		ST_FETCH,
		ST_RD_ADDR,
		ST_RD_OE,
		ST_RD_DATA,
		ST_LOAD_PC,
		ST_DECODE,
		ST_EXEC,
		ST_WRITE,
		ST_WRITE_1,
		ST_BRANCH
	} state_e;

	// what the current three-cycle read is for
	typedef enum logic [1:0] {RD_VEC, RD_FETCH, RD_OPR, RD_MEM} rd_kind_e;

	state_e   state;
	rd_kind_e rd_kind;
	logic     byte_hi;    // next byte read is the high half
	addr_t    ea;         // vector pointer or effective address
	addr_t    rel_target;

	// PC already points past the offset byte here
	assign rel_target = pc_i + {{(ADDR_W - DATA_W){operand_o[DATA_W-1]}}, operand_o};

	always_ff @(posedge cpu_clk or posedge k_reset)
	begin
		if (k_reset)
		begin
			state      <= ST_COLD;
			rd_kind    <= RD_VEC;
			byte_hi    <= 1'b0;
			ea         <= '0;
			opcode_o   <= '0;
			operand_o  <= '0;
			new_pc_o   <= '0;
			rf_ctrl_o  <= '0;
			cpu_addr_o <= '0;
			cpu_data_o <= '0;
			cpu_oe_o   <= 1'b0;
			cpu_we_o   <= 1'b0;
		end
		else
		begin
			rf_ctrl_o <= '0; // strobes self-clear
			cpu_oe_o  <= 1'b0;
			cpu_we_o  <= 1'b0;
			case (state)
				ST_COLD:
				begin
					ea      <= RESET_VECTOR;
					byte_hi <= 1'b1;
					rd_kind <= RD_VEC;
					state   <= ST_RD_ADDR;
				end
				ST_FETCH:
				begin
					cpu_addr_o        <= pc_i;
					rf_ctrl_o.inc_pc  <= 1'b1;
					rd_kind           <= RD_FETCH;
					state             <= ST_RD_OE;
				end
				ST_RD_ADDR:
				begin
					if (rd_kind == RD_OPR)
					begin
						cpu_addr_o       <= pc_i; // operand bytes follow the opcode
						rf_ctrl_o.inc_pc <= 1'b1;
					end
					else
						cpu_addr_o <= ea;
					state <= ST_RD_OE;
				end
				ST_RD_OE:
				begin
					cpu_oe_o <= 1'b1;
					state    <= ST_RD_DATA;
				end
				ST_RD_DATA:
				begin
					case (rd_kind)
						RD_VEC:
						begin
							if (byte_hi)
							begin
								new_pc_o[ADDR_W-1:DATA_W] <= cpu_data_i;
								ea      <= ea + addr_t'(1);
								byte_hi <= 1'b0;
								state   <= ST_RD_ADDR;
							end
							else
							begin
								new_pc_o[DATA_W-1:0] <= cpu_data_i;
								rf_ctrl_o.load_pc    <= 1'b1;
								state                <= ST_LOAD_PC;
							end
						end
						RD_FETCH:
						begin
							opcode_o <= cpu_data_i;
							state    <= ST_DECODE;
						end
						RD_OPR:
						begin
							if (byte_hi)
							begin
								ea[ADDR_W-1:DATA_W] <= cpu_data_i; // extended, high byte first
								byte_hi <= 1'b0;
								state   <= ST_RD_ADDR;
							end
							else if (dec_i.mode == MODE_IMMEDIATE)
							begin
								operand_o <= cpu_data_i;
								state     <= ST_EXEC;
							end
							else if (dec_i.mode == MODE_REL8)
							begin
								operand_o <= cpu_data_i;
								state     <= ST_BRANCH;
							end
							else
							begin
								if (dec_i.mode == MODE_DIRECT)
									ea <= {byte_t'(0), cpu_data_i}; // page zero
								else
									ea[DATA_W-1:0] <= cpu_data_i;
								if (dec_i.op_class == OPC_STORE)
									state <= ST_WRITE;
								else if (dec_i.op_class == OPC_JMP)
									state <= ST_EXEC;
								else
								begin
									rd_kind <= RD_MEM;
									state   <= ST_RD_ADDR;
								end
							end
						end
						default:
						begin
							operand_o <= cpu_data_i; // memory operand
							state     <= ST_EXEC;
						end
					endcase
				end
				ST_LOAD_PC:
					state <= ST_FETCH; // wait for PC to take the new value
				ST_DECODE:
				begin
					if (!dec_i.valid || dec_i.mode == MODE_INHERENT)
						state <= ST_FETCH; // NOP or unknown byte
					else
					begin
						byte_hi <= (dec_i.mode == MODE_EXTENDED);
						rd_kind <= RD_OPR;
						state   <= ST_RD_ADDR;
					end
				end
				ST_EXEC:
				begin
					if (dec_i.op_class == OPC_JMP)
					begin
						new_pc_o          <= ea;
						rf_ctrl_o.load_pc <= 1'b1;
						state             <= ST_LOAD_PC;
					end
					else
					begin
						rf_ctrl_o.write_acc <= 1'b1;
						rf_ctrl_o.write_ccr <= dec_i.writes_flags;
						state               <= ST_FETCH;
					end
				end
				ST_WRITE:
				begin
					cpu_addr_o <= ea;
					cpu_data_o <= acc_i;
					cpu_we_o   <= 1'b1;
					state      <= ST_WRITE_1;
				end
				ST_WRITE_1:
					state <= ST_FETCH;
				ST_BRANCH:
				begin
					if (cond_true_i)
					begin
						new_pc_o          <= rel_target;
						rf_ctrl_o.load_pc <= 1'b1;
						state             <= ST_LOAD_PC;
					end
					else
						state <= ST_FETCH; // not taken, carry on after offset
				end
				default:
					state <= ST_COLD;
			endcase
		end
	end

	a_oe_we_excl: assert property (@(posedge cpu_clk) disable iff (k_reset)
		!(cpu_oe_o && cpu_we_o));

	a_oe_pulse: assert property (@(posedge cpu_clk) disable iff (k_reset)
		cpu_oe_o |=> !cpu_oe_o);

	a_we_pulse: assert property (@(posedge cpu_clk) disable iff (k_reset)
		cpu_we_o |=> !cpu_we_o);

endmodule

// ==== hw/opcode_decoder.sv ====
/*
 * opcode byte to decode record, one table row per supported opcode
 */

`timescale 1ns/1ps

module opcode_decoder import cpu_pkg::*; (
	input  byte_t   opcode_i,
	output decode_t dec_o
);

	function automatic decode_t row(input addr_mode_e mode, input op_class_e op_class,
		input alu_op_e alu_op, input reg_sel_e reg_sel, input logic wf, input cond_e cond);
		return '{mode: mode, op_class: op_class, alu_op: alu_op, reg_sel: reg_sel,
			writes_flags: wf, cond: cond, valid: 1'b1};
	endfunction

	always_comb
	begin
		// anything not listed is skipped by the sequencer
		dec_o = '{mode: MODE_NONE, op_class: OPC_NOP, alu_op: ALU_PASS, reg_sel: REG_A,
			writes_flags: 1'b0, cond: COND_ALWAYS, valid: 1'b0};
		case (opcode_i)
			OP_LDA_IMM:
				dec_o = row(MODE_IMMEDIATE, OPC_ALU, ALU_PASS, REG_A, 1'b1, COND_ALWAYS);
			OP_LDA_EXT:
				dec_o = row(MODE_EXTENDED, OPC_ALU, ALU_PASS, REG_A, 1'b1, COND_ALWAYS);
			OP_LDB_IMM:
				dec_o = row(MODE_IMMEDIATE, OPC_ALU, ALU_PASS, REG_B, 1'b1, COND_ALWAYS);
			OP_ADDA_IMM:
				dec_o = row(MODE_IMMEDIATE, OPC_ALU, ALU_ADD, REG_A, 1'b1, COND_ALWAYS);
			OP_ADDB_IMM:
				dec_o = row(MODE_IMMEDIATE, OPC_ALU, ALU_ADD, REG_B, 1'b1, COND_ALWAYS);
			OP_SUBA_IMM:
				dec_o = row(MODE_IMMEDIATE, OPC_ALU, ALU_SUB, REG_A, 1'b1, COND_ALWAYS);
			OP_ANDA_IMM:
				dec_o = row(MODE_IMMEDIATE, OPC_ALU, ALU_AND, REG_A, 1'b1, COND_ALWAYS);
			OP_STA_DIR:
				dec_o = row(MODE_DIRECT, OPC_STORE, ALU_PASS, REG_A, 1'b0, COND_ALWAYS);
			OP_STA_EXT:
				dec_o = row(MODE_EXTENDED, OPC_STORE, ALU_PASS, REG_A, 1'b0, COND_ALWAYS);
			OP_STB_DIR:
				dec_o = row(MODE_DIRECT, OPC_STORE, ALU_PASS, REG_B, 1'b0, COND_ALWAYS);
			OP_STB_EXT:
				dec_o = row(MODE_EXTENDED, OPC_STORE, ALU_PASS, REG_B, 1'b0, COND_ALWAYS);
			OP_JMP_EXT:
				dec_o = row(MODE_EXTENDED, OPC_JMP, ALU_PASS, REG_A, 1'b0, COND_ALWAYS);
			OP_BRA:
				dec_o = row(MODE_REL8, OPC_BRANCH, ALU_PASS, REG_A, 1'b0, COND_ALWAYS);
			OP_BEQ:
				dec_o = row(MODE_REL8, OPC_BRANCH, ALU_PASS, REG_A, 1'b0, COND_EQ);
			OP_BNE:
				dec_o = row(MODE_REL8, OPC_BRANCH, ALU_PASS, REG_A, 1'b0, COND_NE);
			OP_NOP:
				dec_o = row(MODE_INHERENT, OPC_NOP, ALU_PASS, REG_A, 1'b0, COND_ALWAYS);
			default:
				dec_o.valid = 1'b0;
		endcase
	end

endmodule

// ==== hw/register_file.sv ====
/*
 * accumulators A and B, program counter and condition codes
 */

`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
	input  logic     cpu_clk,
	input  logic     k_reset,
	input  rf_ctrl_t ctrl_i,
	input  reg_sel_e reg_sel_i,
	input  byte_t    acc_wdata_i,
	input  ccr_t     ccr_i,
	input  addr_t    new_pc_i,
	output addr_t    pc_o,
	output byte_t    acc_o,
	output ccr_t     ccr_o
);

	byte_t acc_a;
	byte_t acc_b;
	addr_t pc_q;
	ccr_t  ccr_q;

	always_ff @(posedge cpu_clk or posedge k_reset)
	begin
		if (k_reset)
		begin
			acc_a <= '0;
			acc_b <= '0;
			pc_q  <= '0;
			ccr_q <= '0;
		end
		else
		begin
			if (ctrl_i.load_pc)
				pc_q <= new_pc_i; // vector, jump or branch target
			else if (ctrl_i.inc_pc)
				pc_q <= pc_q + addr_t'(1);
			if (ctrl_i.write_acc)
			begin
				if (reg_sel_i == REG_B)
					acc_b <= acc_wdata_i;
				else
					acc_a <= acc_wdata_i;
			end
			if (ctrl_i.write_ccr)
				ccr_q <= ccr_i;
		end
	end

	assign pc_o  = pc_q;
	assign acc_o = (reg_sel_i == REG_B) ? acc_b : acc_a;
	assign ccr_o = ccr_q;

	a_pc_one_source: assert property (@(posedge cpu_clk) disable iff (k_reset)
		!(ctrl_i.inc_pc && ctrl_i.load_pc));

endmodule

// ==== hw/alu8.sv ====
/*
 * 8-bit ALU with N Z V C flags and branch condition test
 */

`timescale 1ns/1ps

module alu8 import cpu_pkg::*; (
	input  alu_op_e op_i,
	input  byte_t   a_i,
	input  byte_t   b_i,
	input  ccr_t    ccr_i,
	input  cond_e   cond_i,
	output byte_t   result_o,
	output ccr_t    ccr_o,
	output logic    cond_true_o
);

	logic [DATA_W:0] add_w;
	logic [DATA_W:0] sub_w; // top bit is the borrow

	assign add_w = {1'b0, a_i} + {1'b0, b_i};
	assign sub_w = {1'b0, a_i} - {1'b0, b_i};

	always_comb
	begin
		result_o = b_i;
		ccr_o    = ccr_i; // C kept unless the op sets it
		ccr_o.v  = 1'b0;
		case (op_i)
			ALU_ADD:
			begin
				result_o = add_w[DATA_W-1:0];
				ccr_o.c  = add_w[DATA_W];
				ccr_o.v  = (a_i[DATA_W-1] == b_i[DATA_W-1]) &&
					(result_o[DATA_W-1] != a_i[DATA_W-1]);
			end
			ALU_SUB:
			begin
				result_o = sub_w[DATA_W-1:0];
				ccr_o.c  = sub_w[DATA_W];
				ccr_o.v  = (a_i[DATA_W-1] != b_i[DATA_W-1]) &&
					(result_o[DATA_W-1] != a_i[DATA_W-1]);
			end
			ALU_AND:
				result_o = a_i & b_i;
			default:
				result_o = b_i; // load
		endcase
		ccr_o.n = result_o[DATA_W-1];
		ccr_o.z = (result_o == '0);
	end

	always_comb
	begin
		case (cond_i)
			COND_EQ: cond_true_o = ccr_i.z;
			COND_NE: cond_true_o = !ccr_i.z;
			default: cond_true_o = 1'b1;
		endcase
	end

endmodule

// ==== hw/cpu_pkg.sv ====
/*
 * widths, flag and decode types, ALU and addressing enums, opcode values
 */

package cpu_pkg;

	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] byte_t;

	// condition codes kept by the core
	typedef struct packed {
		logic n;
		logic z;
		logic v;
		logic c;
	} ccr_t;

	typedef enum logic [1:0] {ALU_PASS, ALU_ADD, ALU_SUB, ALU_AND} alu_op_e;

	typedef enum logic [2:0] {
		MODE_NONE,
		MODE_INHERENT,
		MODE_IMMEDIATE,
		MODE_DIRECT,
		MODE_EXTENDED,
		MODE_REL8
	} addr_mode_e;

	typedef enum logic [2:0] {OPC_ALU, OPC_STORE, OPC_JMP, OPC_BRANCH, OPC_NOP} op_class_e;

	typedef enum logic [1:0] {COND_ALWAYS, COND_EQ, COND_NE} cond_e;

	typedef enum logic {REG_A, REG_B} reg_sel_e;

	typedef struct packed {
		addr_mode_e mode;
		op_class_e  op_class;
		alu_op_e    alu_op;
		reg_sel_e   reg_sel;
		logic       writes_flags; // flags follow the accumulator write
		cond_e      cond;
		logic       valid;        // low for bytes the core skips
	} decode_t;

	// one-cycle strobes into the register file
	typedef struct packed {
		logic inc_pc;
		logic load_pc;
		logic write_acc;
		logic write_ccr;
	} rf_ctrl_t;

	// 6809 opcode values implemented here
	localparam byte_t OP_NOP      = 8'h12;
	localparam byte_t OP_BRA      = 8'h20;
	localparam byte_t OP_BNE      = 8'h26;
	localparam byte_t OP_BEQ      = 8'h27;
	localparam byte_t OP_JMP_EXT  = 8'h7E;
	localparam byte_t OP_SUBA_IMM = 8'h80;
	localparam byte_t OP_ANDA_IMM = 8'h84;
	localparam byte_t OP_LDA_IMM  = 8'h86;
	localparam byte_t OP_ADDA_IMM = 8'h8B;
	localparam byte_t OP_STA_DIR  = 8'h97;
	localparam byte_t OP_LDA_EXT  = 8'hB6;
	localparam byte_t OP_STA_EXT  = 8'hB7;
	localparam byte_t OP_LDB_IMM  = 8'hC6;
	localparam byte_t OP_ADDB_IMM = 8'hCB;
	localparam byte_t OP_STB_DIR  = 8'hD7;
	localparam byte_t OP_STB_EXT  = 8'hF7;

endpackage
